//--- files.f
verilog/exec_pkg.sv
verilog/exec_unit_if.sv
verilog/exec_csr_if.sv
verilog/exec_ctrl.sv
verilog/exec_alu.sv
verilog/exec_muldiv.sv
verilog/exec_csr.sv
verilog/exec_stage.sv
sim/exec_stage_sva.sv
sim/exec_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_stage_tb -f files.f \
    --Mdir obj_dir -o exec_stage_sim

./obj_dir/exec_stage_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- sim/exec_golden.txt
# op src1 src2 csr pc irq ready_mask kind expected, all hex
# kind 0 expects a result, kind 1 a flush to the low 32 bits of expected
00 0000000000000007 0000000000000005 000 00001000 0 ff 0 000000000000000c
01 0000000000000005 0000000000000007 000 00001004 0 55 0 fffffffffffffffe
02 ffffffffffffffff 0000000000000001 000 00001008 0 33 0 0000000000000001
03 ffffffffffffffff 0000000000000001 000 0000100c 0 ff 0 0000000000000000
04 00000000ff00ff00 000000000ff00ff0 000 00001010 0 11 0 000000000f000f00
05 00000000ff00ff00 000000000ff00ff0 000 00001014 0 ff 0 00000000fff0fff0
06 00000000ff00ff00 000000000ff00ff0 000 00001018 0 55 0 00000000f0f0f0f0
07 0000000000000001 0000000000000043 000 0000101c 0 ff 0 0000000000000008
08 8000000000000000 0000000000000004 000 00001020 0 33 0 0800000000000000
09 8000000000000000 0000000000000004 000 00001024 0 ff 0 f800000000000000
0a 0000000000000006 fffffffffffffffd 000 00001028 0 55 0 ffffffffffffffee
0b ffffffffffffffec 0000000000000003 000 0000102c 0 ff 0 fffffffffffffffa
0d ffffffffffffffec 0000000000000003 000 00001030 0 33 0 fffffffffffffffe
0c 0000000000000064 0000000000000007 000 00001034 0 ff 0 000000000000000e
0e 0000000000000064 0000000000000007 000 00001038 0 55 0 0000000000000002
0b 000000000000002a 0000000000000000 000 0000103c 0 ff 0 ffffffffffffffff
0d 000000000000002a 0000000000000000 000 00001040 0 ff 0 000000000000002a
0b 8000000000000000 ffffffffffffffff 000 00001044 0 55 0 8000000000000000
0d 8000000000000000 ffffffffffffffff 000 00001048 0 ff 0 0000000000000000
0f 0000000000000100 0000000000000000 305 0000104c 0 ff 0 0000000000000000
10 0000000000000003 0000000000000000 305 00001050 0 33 0 0000000000000100
11 0000000000000001 0000000000000000 305 00001054 0 55 0 0000000000000103
10 0000000000000000 0000000000000000 305 00001058 0 ff 0 0000000000000102
12 0000000000000000 0000000000000000 000 00002000 0 ff 1 0000000000000102
10 0000000000000000 0000000000000000 341 00001060 0 ff 0 0000000000002000
10 0000000000000000 0000000000000000 342 00001064 0 55 0 000000000000000b
00 0000000000000001 0000000000000002 000 00003000 1 ff 1 0000000000000102
10 0000000000000000 0000000000000000 342 0000106c 0 ff 0 8000000000000007
13 0000000000000000 0000000000000000 000 00001070 0 ff 1 0000000000003000

//--- sim/exec_stage_sva.sv
`default_nettype none

module exec_stage_sva #(
    parameter int XLEN = exec_pkg::EXEC_XLEN
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  in_ready_i,
    input logic                  out_valid_i,
    input logic                  out_ready_i,
    input logic                  flush_i,
    input exec_pkg::trap_state_t state_i,
    input logic [XLEN-1:0]       result_i,
    input exec_pkg::exec_reg_t   rd_i,
    input exec_pkg::exec_pc_t    pc_i
);
    // A flushed instruction never leaves the stage
    no_flush_with_output: assert property (
        @(posedge clk) disable iff (reset)
        flush_i |-> !out_valid_i ##1 (!out_valid_i && !flush_i)
    ) else $error("Flushed instruction produced output or flush lasted over a cycle");

    // Trap sequence closes the stage for two cycles and then reopens it empty
    closed_during_trap: assert property (
        @(posedge clk) disable iff (reset)
        state_i == exec_pkg::TRAP_MEPC |->
            !in_ready_i ##1 !in_ready_i ##1 (in_ready_i && !out_valid_i)
    ) else $error("Stage not closed during the trap sequence or not empty after it");

    hold_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        out_valid_i && !out_ready_i |=>
            out_valid_i && $stable(result_i) && $stable(rd_i) && $stable(pc_i)
    ) else $error("Output changed while stalled");
endmodule

bind exec_ctrl exec_stage_sva #(
    .XLEN(XLEN)
) exec_stage_sva_i (
    .clk         (clk),
    .reset       (reset),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .flush_i     (flush_o),
    .state_i     (state_q),
    .result_i    (out_result_o),
    .rd_i        (out_rd_o),
    .pc_i        (out_pc_o)
);

`default_nettype wire

//--- sim/exec_stage_tb.sv
`default_nettype none

module exec_stage_tb;

    localparam int XLEN = exec_pkg::EXEC_XLEN;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     in_valid_i;
    logic                     in_ready_o;
    exec_pkg::exec_op_t       in_op_i;
    exec_pkg::exec_word_t     in_src1_i;
    exec_pkg::exec_word_t     in_src2_i;
    exec_pkg::exec_reg_t      in_rd_i;
    exec_pkg::exec_pc_t       in_pc_i;
    exec_pkg::exec_csr_addr_t in_csr_i;
    logic                     out_valid_o;
    logic                     out_ready_i;
    exec_pkg::exec_word_t     out_result_o;
    exec_pkg::exec_reg_t      out_rd_o;
    exec_pkg::exec_pc_t       out_pc_o;
    logic                     flush_o;
    exec_pkg::exec_pc_t       flush_pc_o;
    logic                     timer_irq_i;

    // One entry per golden line
    exec_pkg::exec_op_t       g_op[$];
    exec_pkg::exec_word_t     g_src1[$];
    exec_pkg::exec_word_t     g_src2[$];
    exec_pkg::exec_csr_addr_t g_csr[$];
    exec_pkg::exec_pc_t       g_pc[$];
    logic                     g_irq[$];
    logic [7:0]               g_ready[$];
    logic                     g_flush[$];
    exec_pkg::exec_word_t     g_value[$];

    int cycle_count = 0;
    int cycle_limit = 1000000;

    exec_stage #(
        .XLEN(XLEN)
    ) exec_stage_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_op_i      (in_op_i),
        .in_src1_i    (in_src1_i),
        .in_src2_i    (in_src2_i),
        .in_rd_i      (in_rd_i),
        .in_pc_i      (in_pc_i),
        .in_csr_i     (in_csr_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_result_o (out_result_o),
        .out_rd_o     (out_rd_o),
        .out_pc_o     (out_pc_o),
        .flush_o      (flush_o),
        .flush_pc_o   (flush_pc_o),
        .timer_irq_i  (timer_irq_i)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_now("Run timed out before all golden lines completed");
        end
    end

    // ------------------------------------------------------------
    // Reporting and checks
    // ------------------------------------------------------------
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input exec_pkg::exec_word_t got,
                              input exec_pkg::exec_word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            fail_now("Data word mismatch");
        end
    endtask

    task automatic check_pc(input string name, input exec_pkg::exec_pc_t got,
                            input exec_pkg::exec_pc_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            fail_now("Address mismatch");
        end
    endtask

    task automatic check_reg(input string name, input exec_pkg::exec_reg_t got,
                             input exec_pkg::exec_reg_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            fail_now("Destination register mismatch");
        end
    endtask

    // Nothing may come out while no instruction is outstanding
    task automatic check_idle();
        if (out_valid_o || flush_o) begin
            fail_now("Output or flush seen with no instruction outstanding");
        end
    endtask

    function automatic logic pick_ready(input logic [7:0] mask);
        pick_ready = mask[$urandom % 8];
    endfunction

    // ------------------------------------------------------------
    // Golden file
    // ------------------------------------------------------------
    task automatic read_golden();
        int                       fd;
        int                       n;
        string                    line;
        exec_pkg::exec_op_t       op;
        exec_pkg::exec_word_t     src1;
        exec_pkg::exec_word_t     src2;
        exec_pkg::exec_csr_addr_t csr;
        exec_pkg::exec_pc_t       pc;
        logic                     irq;
        logic [7:0]               ready;
        logic                     kind;
        exec_pkg::exec_word_t     value;
        fd = $fopen("sim/exec_golden.txt", "r");
        if (fd == 0) begin
            fail_now("Could not open sim/exec_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            op, src1, src2, csr, pc, irq, ready, kind, value);
                if (n != 9) begin
                    fail_now("Malformed line in the golden file");
                end
                g_op.push_back(op);
                g_src1.push_back(src1);
                g_src2.push_back(src2);
                g_csr.push_back(csr);
                g_pc.push_back(pc);
                g_irq.push_back(irq);
                g_ready.push_back(ready);
                g_flush.push_back(kind);
                g_value.push_back(value);
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // One instruction from issue to result or flush
    // ------------------------------------------------------------
    task automatic run_vector(input int idx);
        logic               done;
        logic               held;
        exec_pkg::exec_pc_t exp_pc;
        done = 1'b0;
        held = 1'b0;
        exp_pc = exec_pkg::exec_pc_t'(g_value[idx]);
        // The cycle after a taken result or flush must be quiet
        @(negedge clk);
        check_idle();
        if (g_irq[idx]) begin
            @(posedge clk);
            timer_irq_i <= 1'b1;
            @(posedge clk);
            timer_irq_i <= 1'b0;
        end
        @(posedge clk);
        in_valid_i <= 1'b1;
        in_op_i <= g_op[idx];
        in_src1_i <= g_src1[idx];
        in_src2_i <= g_src2[idx];
        in_rd_i <= exec_pkg::exec_reg_t'(idx);
        in_pc_i <= g_pc[idx];
        in_csr_i <= g_csr[idx];
        @(negedge clk);
        while (!in_ready_o) begin
            check_idle();
            @(negedge clk);
        end
        check_idle();
        @(posedge clk);
        in_valid_i <= 1'b0;
        out_ready_i <= pick_ready(g_ready[idx]);
        while (!done) begin
            @(negedge clk);
            if (flush_o) begin
                if (!g_flush[idx]) begin
                    fail_now("Flush from an instruction that should produce a result");
                end
                check_pc("flush_pc_o", flush_pc_o, exp_pc);
                done = 1'b1;
            end else if (out_valid_o) begin
                if (g_flush[idx]) begin
                    fail_now("Result from an instruction that should flush");
                end
                // Compared every cycle so a held result cannot drift
                check_word("out_result_o", out_result_o, g_value[idx]);
                check_reg("out_rd_o", out_rd_o, exec_pkg::exec_reg_t'(idx));
                check_pc("out_pc_o", out_pc_o, g_pc[idx]);
                held = 1'b1;
                done = out_ready_i;
            end else if (held) begin
                fail_now("Result withdrawn before it was taken");
            end
            @(posedge clk);
            out_ready_i <= pick_ready(g_ready[idx]);
        end
    endtask

    initial begin
        void'($urandom(63));
        reset = 1'b1;
        in_valid_i = 1'b0;
        in_op_i = exec_pkg::OP_ADD;
        in_src1_i = '0;
        in_src2_i = '0;
        in_rd_i = '0;
        in_pc_i = '0;
        in_csr_i = '0;
        out_ready_i = 1'b0;
        timer_irq_i = 1'b0;
        read_golden();
        cycle_limit = g_op.size() * (XLEN + 16) + 100;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < g_op.size(); i++) begin
            run_vector(i);
        end
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/exec_alu.sv
`default_nettype none

module exec_alu #(
    parameter int XLEN = exec_pkg::EXEC_XLEN
) (
    exec_unit_if.comb_unit bus
);
    localparam int SH_W = $clog2(XLEN);

    logic [SH_W-1:0] shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lt_signed;
    logic            lt_unsigned;

    always_comb begin
        shamt = bus.src2[SH_W-1:0];
        sum = bus.src1 + bus.src2;
        diff = bus.src1 - bus.src2;
        lt_signed = $signed(bus.src1) < $signed(bus.src2);
        lt_unsigned = bus.src1 < bus.src2;
    end

    // ------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------
    always_comb begin
        case (bus.op)
            exec_pkg::OP_SUB: begin
                bus.result = diff;
            end
            exec_pkg::OP_SLT: begin
                bus.result = {{(XLEN - 1){1'b0}}, lt_signed};
            end
            exec_pkg::OP_SLTU: begin
                bus.result = {{(XLEN - 1){1'b0}}, lt_unsigned};
            end
            exec_pkg::OP_AND: begin
                bus.result = bus.src1 & bus.src2;
            end
            exec_pkg::OP_OR: begin
                bus.result = bus.src1 | bus.src2;
            end
            exec_pkg::OP_XOR: begin
                bus.result = bus.src1 ^ bus.src2;
            end
            exec_pkg::OP_SLL: begin
                bus.result = bus.src1 << shamt;
            end
            exec_pkg::OP_SRL: begin
                bus.result = bus.src1 >> shamt;
            end
            exec_pkg::OP_SRA: begin
                // Sign bit fills from the left
                bus.result = $unsigned($signed(bus.src1) >>> shamt);
            end
            default: begin
                bus.result = sum;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exec_csr.sv
`default_nettype none

module exec_csr (
    input  logic    clk,
    input  logic    reset,
    input  logic    timer_irq_i,
    exec_csr_if.csr csr_bus
);
    exec_pkg::exec_word_t mtvec_q;
    exec_pkg::exec_word_t mepc_q;
    exec_pkg::exec_word_t mcause_q;
    logic                 irq_pending_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec_q <= '0;
            mepc_q <= '0;
            mcause_q <= '0;
        end else if (csr_bus.we) begin
            case (csr_bus.addr)
                exec_pkg::CSR_MTVEC:  mtvec_q <= csr_bus.wdata;
                exec_pkg::CSR_MEPC:   mepc_q <= csr_bus.wdata;
                exec_pkg::CSR_MCAUSE: mcause_q <= csr_bus.wdata;
                default: begin
                end
            endcase
        end
    end

    // A new timer pulse wins over the clear
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_pending_q <= 1'b0;
        end else if (timer_irq_i) begin
            irq_pending_q <= 1'b1;
        end else if (csr_bus.trap_taken) begin
            irq_pending_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    always_comb begin
        case (csr_bus.addr)
            exec_pkg::CSR_MTVEC:  csr_bus.rdata = mtvec_q;
            exec_pkg::CSR_MEPC:   csr_bus.rdata = mepc_q;
            exec_pkg::CSR_MCAUSE: csr_bus.rdata = mcause_q;
            default:              csr_bus.rdata = '0;
        endcase
    end

    assign csr_bus.irq_pending = irq_pending_q;

endmodule

`default_nettype wire

//--- verilog/exec_csr_if.sv
`default_nettype none

interface exec_csr_if;
    logic                     we;
    exec_pkg::exec_csr_addr_t addr;
    exec_pkg::exec_word_t     wdata;
    exec_pkg::exec_word_t     rdata;
    logic                     irq_pending;
    logic                     trap_taken;

    modport ctrl (
        output we, addr, wdata, trap_taken,
        input  rdata, irq_pending
    );
    modport csr (
        input  we, addr, wdata, trap_taken,
        output rdata, irq_pending
    );
endinterface

`default_nettype wire

//--- verilog/exec_ctrl.sv
`default_nettype none

module exec_ctrl #(
    parameter int XLEN = exec_pkg::EXEC_XLEN
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  exec_pkg::exec_op_t       in_op_i,
    input  logic [XLEN-1:0]          in_src1_i,
    input  logic [XLEN-1:0]          in_src2_i,
    input  exec_pkg::exec_reg_t      in_rd_i,
    input  exec_pkg::exec_pc_t       in_pc_i,
    input  exec_pkg::exec_csr_addr_t in_csr_i,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output logic [XLEN-1:0]          out_result_o,
    output exec_pkg::exec_reg_t      out_rd_o,
    output exec_pkg::exec_pc_t       out_pc_o,
    output logic                     flush_o,
    output exec_pkg::exec_pc_t       flush_pc_o,
    exec_unit_if.ctrl                alu_bus,
    exec_unit_if.ctrl                md_bus,
    exec_csr_if.ctrl                 csr_bus
);
    logic                     valid_q;
    logic                     fresh_q;
    logic                     cause_irq_q;
    exec_pkg::trap_state_t    state_q;

    exec_pkg::exec_op_t       op_q;
    logic [XLEN-1:0]          src1_q;
    logic [XLEN-1:0]          src2_q;
    exec_pkg::exec_reg_t      rd_q;
    exec_pkg::exec_pc_t       pc_q;
    exec_pkg::exec_csr_addr_t csr_q;

    logic                     accept;
    logic                     is_md;
    logic                     is_csr;
    logic                     trap;
    logic                     mret_flush;
    logic                     ready_go;
    logic                     out_fire;
    exec_pkg::exec_word_t     csr_src;

    // ------------------------------------------------------------
    // Handshake and stage status
    // ------------------------------------------------------------
    always_comb begin
        is_md = op_q inside {exec_pkg::OP_MUL, exec_pkg::OP_DIV, exec_pkg::OP_DIVU,
                             exec_pkg::OP_REM, exec_pkg::OP_REMU};
        is_csr = op_q inside {exec_pkg::OP_CSRRW, exec_pkg::OP_CSRRS, exec_pkg::OP_CSRRC};
        // Pending interrupt only taken on an instruction's first cycle
        trap = fresh_q && (op_q == exec_pkg::OP_ECALL || csr_bus.irq_pending);
        mret_flush = fresh_q && op_q == exec_pkg::OP_MRET && !csr_bus.irq_pending;
        flush_o = trap || mret_flush;
        ready_go = state_q == exec_pkg::TRAP_IDLE && !flush_o &&
                   (!is_md || (md_bus.done && !fresh_q));
        out_valid_o = valid_q && ready_go;
        out_fire = out_valid_o && out_ready_i;
        in_ready_o = state_q == exec_pkg::TRAP_IDLE && (!valid_q || (ready_go && out_ready_i));
        accept = in_valid_i && in_ready_o;
    end

    assign out_result_o = is_md  ? md_bus.result :
                          is_csr ? XLEN'(csr_bus.rdata) :
                                   alu_bus.result;
    assign out_rd_o   = rd_q;
    assign out_pc_o   = pc_q;
    assign flush_pc_o = exec_pkg::exec_pc_t'(csr_bus.rdata);

    // ALU needs no start or kill
    assign alu_bus.start = 1'b0;
    assign alu_bus.kill  = 1'b0;
    assign alu_bus.op    = op_q;
    assign alu_bus.src1  = src1_q;
    assign alu_bus.src2  = src2_q;

    assign md_bus.start = fresh_q && is_md && !flush_o;
    assign md_bus.kill  = flush_o;
    assign md_bus.op    = op_q;
    assign md_bus.src1  = src1_q;
    assign md_bus.src2  = src2_q;

    // ------------------------------------------------------------
    // CSR access
    // ------------------------------------------------------------
    always_comb begin
        csr_src = exec_pkg::exec_word_t'(src1_q);
        csr_bus.we = 1'b0;
        csr_bus.addr = csr_q;
        case (op_q)
            exec_pkg::OP_CSRRS: csr_bus.wdata = csr_src | csr_bus.rdata;
            exec_pkg::OP_CSRRC: csr_bus.wdata = csr_bus.rdata & ~csr_src;
            default:            csr_bus.wdata = csr_src;
        endcase
        if (trap) begin
            csr_bus.addr = exec_pkg::CSR_MTVEC;
        end else if (mret_flush) begin
            csr_bus.addr = exec_pkg::CSR_MEPC;
        end else if (out_fire && is_csr) begin
            // Old value stays readable until the result is taken
            csr_bus.we = 1'b1;
        end
        case (state_q)
            exec_pkg::TRAP_MEPC: begin
                csr_bus.we = 1'b1;
                csr_bus.addr = exec_pkg::CSR_MEPC;
                csr_bus.wdata = exec_pkg::exec_word_t'(pc_q);
            end
            exec_pkg::TRAP_MCAUSE: begin
                csr_bus.we = 1'b1;
                csr_bus.addr = exec_pkg::CSR_MCAUSE;
                csr_bus.wdata = cause_irq_q ? exec_pkg::CAUSE_TIMER : exec_pkg::CAUSE_ECALL;
            end
            default: begin
            end
        endcase
    end

    assign csr_bus.trap_taken = trap;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            fresh_q <= 1'b0;
            cause_irq_q <= 1'b0;
            state_q <= exec_pkg::TRAP_IDLE;
        end else begin
            fresh_q <= accept;
            if (in_ready_o) begin
                valid_q <= in_valid_i;
            end else if (mret_flush || state_q == exec_pkg::TRAP_MCAUSE) begin
                valid_q <= 1'b0;
            end
            case (state_q)
                exec_pkg::TRAP_IDLE: begin
                    if (trap) begin
                        state_q <= exec_pkg::TRAP_MEPC;
                        cause_irq_q <= csr_bus.irq_pending;
                    end
                end
                exec_pkg::TRAP_MEPC: state_q <= exec_pkg::TRAP_MCAUSE;
                default:             state_q <= exec_pkg::TRAP_IDLE;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= in_op_i;
            src1_q <= in_src1_i;
            src2_q <= in_src2_i;
            rd_q <= in_rd_i;
            pc_q <= in_pc_i;
            csr_q <= in_csr_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/exec_muldiv.sv
`default_nettype none

module exec_muldiv #(
    parameter int XLEN = exec_pkg::EXEC_XLEN
) (
    input  logic          clk,
    input  logic          reset,
    exec_unit_if.seq_unit bus
);
    localparam int CNT_W = $clog2(XLEN);

    logic               busy_q;
    logic               done_q;
    logic [CNT_W-1:0]   cnt_q;
    exec_pkg::exec_op_t op_q;
    logic [XLEN-1:0]    acc_q;
    logic [XLEN-1:0]    a_q;
    logic [XLEN-1:0]    b_q;
    logic               quo_neg_q;
    logic               rem_neg_q;
    logic               div0_q;

    logic               is_signed;
    logic               s1_neg;
    logic               s2_neg;
    logic [XLEN-1:0]    s1_mag;
    logic [XLEN-1:0]    s2_mag;
    logic [XLEN:0]      rem_shift;
    logic [XLEN:0]      trial;

    always_comb begin
        is_signed = bus.op == exec_pkg::OP_DIV || bus.op == exec_pkg::OP_REM;
        s1_neg = is_signed && bus.src1[XLEN-1];
        s2_neg = is_signed && bus.src2[XLEN-1];
        s1_mag = s1_neg ? -bus.src1 : bus.src1;
        s2_mag = s2_neg ? -bus.src2 : bus.src2;
        // Restoring step, borrow in the top bit means no subtract
        rem_shift = {acc_q, a_q[XLEN-1]};
        trial = rem_shift - {1'b0, b_q};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q <= '0;
        end else if (bus.kill) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (bus.start) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(XLEN - 1)) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (bus.start) begin
            op_q <= bus.op;
            acc_q <= '0;
            a_q <= s1_mag;
            b_q <= s2_mag;
            quo_neg_q <= s1_neg ^ s2_neg;
            rem_neg_q <= s1_neg;
            div0_q <= bus.src2 == '0;
        end else if (busy_q) begin
            if (op_q == exec_pkg::OP_MUL) begin
                if (b_q[0]) begin
                    acc_q <= acc_q + a_q;
                end
                a_q <= a_q << 1;
                b_q <= b_q >> 1;
            end else begin
                acc_q <= trial[XLEN] ? rem_shift[XLEN-1:0] : trial[XLEN-1:0];
                a_q <= {a_q[XLEN-2:0], ~trial[XLEN]};
            end
        end
    end

    // Sign fix-up, overflow case falls out of the magnitudes
    always_comb begin
        case (op_q)
            exec_pkg::OP_MUL: bus.result = acc_q;
            exec_pkg::OP_DIV,
            exec_pkg::OP_DIVU: bus.result = div0_q ? '1 : (quo_neg_q ? -a_q : a_q);
            default:           bus.result = rem_neg_q ? -acc_q : acc_q;
        endcase
    end

    assign bus.done = done_q;

endmodule

`default_nettype wire

//--- verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // Default data width, the top level may override it
    localparam int EXEC_XLEN = 64;

    typedef logic [EXEC_XLEN-1:0] exec_word_t;
    typedef logic [31:0]          exec_pc_t;
    typedef logic [4:0]           exec_op_t;
    typedef logic [11:0]          exec_csr_addr_t;
    typedef logic [4:0]           exec_reg_t;

    // ------------------------------------------------------------
    // Operation codes
    // ------------------------------------------------------------
    localparam exec_op_t OP_ADD   = 5'd0;
    localparam exec_op_t OP_SUB   = 5'd1;
    localparam exec_op_t OP_SLT   = 5'd2;
    localparam exec_op_t OP_SLTU  = 5'd3;
    localparam exec_op_t OP_AND   = 5'd4;
    localparam exec_op_t OP_OR    = 5'd5;
    localparam exec_op_t OP_XOR   = 5'd6;
    localparam exec_op_t OP_SLL   = 5'd7;
    localparam exec_op_t OP_SRL   = 5'd8;
    localparam exec_op_t OP_SRA   = 5'd9;
    localparam exec_op_t OP_MUL   = 5'd10;
    localparam exec_op_t OP_DIV   = 5'd11;
    localparam exec_op_t OP_DIVU  = 5'd12;
    localparam exec_op_t OP_REM   = 5'd13;
    localparam exec_op_t OP_REMU  = 5'd14;
    localparam exec_op_t OP_CSRRW = 5'd15;
    localparam exec_op_t OP_CSRRS = 5'd16;
    localparam exec_op_t OP_CSRRC = 5'd17;
    localparam exec_op_t OP_ECALL = 5'd18;
    localparam exec_op_t OP_MRET  = 5'd19;

    // Machine CSRs
    localparam exec_csr_addr_t CSR_MTVEC  = 12'h305;
    localparam exec_csr_addr_t CSR_MEPC   = 12'h341;
    localparam exec_csr_addr_t CSR_MCAUSE = 12'h342;

    localparam exec_word_t CAUSE_ECALL = exec_word_t'(11);
    localparam exec_word_t CAUSE_TIMER = {1'b1, {(EXEC_XLEN - 4){1'b0}}, 3'd7};

    typedef enum logic [1:0] {
        TRAP_IDLE,
        TRAP_MEPC,
        TRAP_MCAUSE
    } trap_state_t;

endpackage

`default_nettype wire

//--- verilog/exec_stage.sv
`default_nettype none

module exec_stage #(
    parameter int XLEN = exec_pkg::EXEC_XLEN
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  exec_pkg::exec_op_t       in_op_i,
    input  logic [XLEN-1:0]          in_src1_i,
    input  logic [XLEN-1:0]          in_src2_i,
    input  exec_pkg::exec_reg_t      in_rd_i,
    input  exec_pkg::exec_pc_t       in_pc_i,
    input  exec_pkg::exec_csr_addr_t in_csr_i,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output logic [XLEN-1:0]          out_result_o,
    output exec_pkg::exec_reg_t      out_rd_o,
    output exec_pkg::exec_pc_t       out_pc_o,
    output logic                     flush_o,
    output exec_pkg::exec_pc_t       flush_pc_o,
    input  logic                     timer_irq_i
);
    exec_unit_if #(.XLEN(XLEN)) alu_bus ();
    exec_unit_if #(.XLEN(XLEN)) md_bus ();
    exec_csr_if                 csr_bus ();

    exec_ctrl #(
        .XLEN(XLEN)
    ) exec_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_op_i      (in_op_i),
        .in_src1_i    (in_src1_i),
        .in_src2_i    (in_src2_i),
        .in_rd_i      (in_rd_i),
        .in_pc_i      (in_pc_i),
        .in_csr_i     (in_csr_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_result_o (out_result_o),
        .out_rd_o     (out_rd_o),
        .out_pc_o     (out_pc_o),
        .flush_o      (flush_o),
        .flush_pc_o   (flush_pc_o),
        .alu_bus      (alu_bus.ctrl),
        .md_bus       (md_bus.ctrl),
        .csr_bus      (csr_bus.ctrl)
    );

    exec_alu #(
        .XLEN(XLEN)
    ) exec_alu_i (
        .bus (alu_bus.comb_unit)
    );

    exec_muldiv #(
        .XLEN(XLEN)
    ) exec_muldiv_i (
        .clk   (clk),
        .reset (reset),
        .bus   (md_bus.seq_unit)
    );

    exec_csr exec_csr_i (
        .clk         (clk),
        .reset       (reset),
        .timer_irq_i (timer_irq_i),
        .csr_bus     (csr_bus.csr)
    );

endmodule

`default_nettype wire

//--- verilog/exec_unit_if.sv
`default_nettype none

interface exec_unit_if #(
    parameter int XLEN = exec_pkg::EXEC_XLEN
);
    logic               start;
    logic               kill;
    exec_pkg::exec_op_t op;
    logic [XLEN-1:0]    src1;
    logic [XLEN-1:0]    src2;
    logic [XLEN-1:0]    result;
    logic               done;

    modport ctrl (output start, op, src1, src2, kill, input result, done);

    // Single-cycle unit sees only operands and result
    modport comb_unit (input op, src1, src2, output result);

    modport seq_unit (input start, op, src1, src2, kill, output result, done);
endinterface

`default_nettype wire
